// File: sim/csr_stim.txt
# W addr data | R addr expect | B addr expect hold | E code pc | F | T | H hw_int
# N cycles | C plv ie era cpu_interrupt     (all values hex)
R 0000 00000008
W 0010 ffffffff
R 0010 00001bff
W 0030 1c000040
R 0030 1c000040
W 0018 80001234
R 0018 80001234
R 0020 00000000
W 0010 00000000
W 0000 00000007
C 3 1 80001234 0
E 0d 1c000100
F
C 0 0 1c000100 0
R 0004 00000007
R 0014 000d0000
T
C 3 1 1c000100 0
E 0a 1c000200
C 0 0 1c000200 0
T
N 3
C 3 1 1c000200 0
F
R 0014 000a0000
W 0010 00000010
H 04
C 3 1 1c000200 1
R 0014 000a0010
W 0010 00000000
C 3 1 1c000200 0
H 00
W 0010 00000001
W 0014 00000001
C 3 1 1c000200 1
W 0014 00000000
C 3 1 1c000200 0
W 0104 00000015
N a
R 0014 000a0800
R 0108 00000000
W 0010 00000800
C 3 1 1c000200 1
W 0110 00000001
C 3 1 1c000200 0
R 0014 000a0000
W 0010 00000000
B 0018 1c000200 6
B 0030 1c000040 4

// File: sources.f
logic/csr_pkg.sv
logic/csr_bus_if.sv
logic/csr_axil_port.sv
logic/csr_except.sv
logic/csr_timer.sv
logic/csr_top.sv
sim/tb_clock.sv
sim/csr_chk.sv
sim/csr_monitor.sv
sim/csr_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module csr_tb -f sources.f -Mdir obj_dir -o csr_sim \
    && ./obj_dir/csr_sim | tee /dev/stderr | grep -qx "All tests passed" \
    && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim/csr_tb.sv
module csr_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam string STIM_FILE = "sim/csr_stim.txt";

    logic               clk;
    logic               aresetn;
    logic               awvalid;
    logic               awready;
    csr_pkg::axi_addr_t awaddr;
    logic               wvalid;
    logic               wready;
    csr_pkg::csr_word_t wdata;
    logic [3:0]         wstrb;
    logic               bvalid;
    logic               bready;
    logic [1:0]         bresp;
    logic               arvalid;
    logic               arready;
    csr_pkg::axi_addr_t araddr;
    logic               rvalid;
    logic               rready;
    csr_pkg::csr_word_t rdata;
    logic [1:0]         rresp;
    logic               excp_valid;
    csr_pkg::ecode_t    excp_code;
    csr_pkg::csr_word_t excp_pc;
    logic               ertn;
    logic [7:0]         hw_int;
    csr_pkg::plv_t      plv;
    logic               ie;
    csr_pkg::csr_word_t era;
    csr_pkg::csr_word_t eentry;
    logic               cpu_interrupt;

    logic               core_check;
    logic               finish;
    logic               reported;
    int                 errors;
    int                 tb_errors = 0;
    int                 limit_cycles = 0;
    logic [7:0]         ops[$];
    csr_pkg::csr_word_t arg_a[$];
    csr_pkg::csr_word_t arg_b[$];
    csr_pkg::csr_word_t arg_c[$];

    tb_clock clock_i (.clk(clk), .aresetn(aresetn));

    csr_top #(.TIMER_BITS(32)) dut_i (.*);

    csr_monitor monitor_i (.*);

    task automatic load_stim();
        int                 fd;
        int                 n;
        string              line;
        csr_pkg::csr_word_t a, b, c, d;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open %s", STIM_FILE);
            tb_errors = tb_errors + 1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.getc(0) >= "A" && line.getc(0) <= "Z") begin
                    a = '0;
                    b = '0;
                    c = '0;
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d);
                    ops.push_back(line.getc(0));
                    arg_a.push_back(a);
                    arg_b.push_back(b);
                    arg_c.push_back(c);
                    // Waits and read holds lengthen the run
                    if (line.getc(0) == "N")
                        limit_cycles = limit_cycles + int'(a);
                    if (line.getc(0) == "B")
                        limit_cycles = limit_cycles + int'(c);
                end
            end
            $fclose(fd);
        end
        limit_cycles = limit_cycles + 40 * (ops.size() + 1);
    endtask

    task automatic write_csr(input csr_pkg::csr_word_t addr, input csr_pkg::csr_word_t data);
        @(posedge clk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr[15:0];
        wdata   <= data;
        bready  <= 1'b0;
        @(posedge clk);
        while (!(awready && wready))
            @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(posedge clk);
        while (!bvalid)
            @(posedge clk);
        // Response stalls one cycle before bready
        bready <= 1'b1;
        @(posedge clk);
    endtask

    // hold > 0 keeps rready low for that many cycles once rvalid is up
    task automatic read_csr(input csr_pkg::csr_word_t addr, input int hold);
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr[15:0];
        if (hold != 0)
            rready <= 1'b0;
        @(posedge clk);
        while (!arready)
            @(posedge clk);
        arvalid <= 1'b0;
        @(posedge clk);
        while (!rvalid)
            @(posedge clk);
        if (hold != 0) begin
            repeat (hold) @(posedge clk);
            rready <= 1'b1;
            @(posedge clk);
        end
    endtask

    initial begin
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        wstrb      = 4'hF;
        bready     = 1'b1;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b1;
        excp_valid = 1'b0;
        excp_code  = '0;
        excp_pc    = '0;
        ertn       = 1'b0;
        hw_int     = '0;
        core_check = 1'b0;
        finish     = 1'b0;
        load_stim();
        @(posedge clk);
        while (!aresetn)
            @(posedge clk);
        foreach (ops[i]) begin
            case (ops[i])
                "W": write_csr(arg_a[i], arg_b[i]);
                "R": read_csr(arg_a[i], 0);
                "B": read_csr(arg_a[i], int'(arg_c[i]));
                "E": begin
                    @(posedge clk);
                    excp_valid <= 1'b1;
                    excp_code  <= arg_a[i][5:0];
                    excp_pc    <= arg_b[i];
                end
                "F": begin
                    @(posedge clk);
                    excp_valid <= 1'b0;
                end
                "T": begin
                    @(posedge clk);
                    ertn <= 1'b1;
                    @(posedge clk);
                    ertn <= 1'b0;
                end
                "H": begin
                    @(posedge clk);
                    hw_int <= arg_a[i][7:0];
                end
                "N": repeat (arg_a[i]) @(posedge clk);
                "C": begin
                    @(posedge clk);
                    core_check <= 1'b1;
                    @(posedge clk);
                    core_check <= 1'b0;
                end
                default: begin
                    $display("Unknown operation %c in the stim file", ops[i]);
                    tb_errors = tb_errors + 1;
                end
            endcase
        end
        @(posedge clk);
        finish <= 1'b1;
        @(posedge clk);
        while (reported !== 1'b1)
            @(posedge clk);
        if (errors == 0 && tb_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the DUT stopped responding", limit_cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: sim/csr_monitor.sv
module csr_monitor (
    input  logic               clk,
    input  logic               bvalid,
    input  logic               bready,
    input  logic [1:0]         bresp,
    input  logic               rvalid,
    input  logic               rready,
    input  csr_pkg::csr_word_t rdata,
    input  logic [1:0]         rresp,
    input  csr_pkg::plv_t      plv,
    input  logic               ie,
    input  csr_pkg::csr_word_t era,
    input  csr_pkg::csr_word_t eentry,
    input  logic               cpu_interrupt,
    input  logic               core_check,
    input  logic               finish,
    input  int                 tb_errors,
    output int                 errors,
    output logic               reported
);
    timeunit 1ns;
    timeprecision 1ps;

    csr_pkg::csr_word_t exp_raddr[$];
    csr_pkg::csr_word_t exp_rdata[$];
    csr_pkg::csr_word_t exp_plv[$];
    csr_pkg::csr_word_t exp_ie[$];
    csr_pkg::csr_word_t exp_era[$];
    csr_pkg::csr_word_t exp_irq[$];
    csr_pkg::csr_word_t rd_addr;
    csr_pkg::csr_word_t rd_want;
    int                 read_errs = 0;
    int                 core_errs = 0;
    int                 resp_errs = 0;
    int                 missing = 0;

    assign errors = read_errs + core_errs + resp_errs + missing;

    function automatic int mismatch(input string name, input csr_pkg::csr_word_t got,
                                    input csr_pkg::csr_word_t want);
        if (got !== want) begin
            $display("ERR %0t ns %s got %h expected %h", $time, name, got, want);
            return 1;
        end
        return 0;
    endfunction

    // Expected values in file order
    initial begin
        int                 fd;
        int                 n;
        string              line;
        csr_pkg::csr_word_t a, b, c, d;

        fd = $fopen("sim/csr_stim.txt", "r");
        if (fd == 0) begin
            $display("Monitor could not open the stim file");
            missing = missing + 1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d);
                case (line.getc(0))
                    "R", "B": begin
                        exp_raddr.push_back(a);
                        exp_rdata.push_back(b);
                    end
                    "C": begin
                        exp_plv.push_back(a);
                        exp_ie.push_back(b);
                        exp_era.push_back(c);
                        exp_irq.push_back(d);
                    end
                    default: ;
                endcase
            end
            $fclose(fd);
        end
    end

    always @(posedge clk) begin
        // OKAY is the only response
        if (bvalid && bready)
            resp_errs = resp_errs + mismatch("bresp", csr_pkg::csr_word_t'(bresp), 32'h0);
        if (rvalid && rready) begin
            resp_errs = resp_errs + mismatch("rresp", csr_pkg::csr_word_t'(rresp), 32'h0);
            if (exp_rdata.size() == 0) begin
                $display("Read response at %0t ns with no expected value left", $time);
                missing = missing + 1;
            end else begin
                rd_addr   = exp_raddr.pop_front();
                rd_want   = exp_rdata.pop_front();
                read_errs = read_errs + mismatch("rdata", rdata, rd_want);
                // EENTRY is also a core output
                if (rd_addr[15:2] == csr_pkg::CSR_EENTRY)
                    read_errs = read_errs + mismatch("eentry", eentry, rd_want);
            end
        end
        if (core_check) begin
            if (exp_plv.size() == 0) begin
                $display("Core check at %0t ns with no expected values left", $time);
                missing = missing + 1;
            end else begin
                core_errs = core_errs + mismatch("plv", csr_pkg::csr_word_t'(plv),
                                                 exp_plv.pop_front());
                core_errs = core_errs + mismatch("ie", csr_pkg::csr_word_t'(ie),
                                                 exp_ie.pop_front());
                core_errs = core_errs + mismatch("era", era, exp_era.pop_front());
                core_errs = core_errs + mismatch("cpu_interrupt",
                                                 csr_pkg::csr_word_t'(cpu_interrupt),
                                                 exp_irq.pop_front());
            end
        end
        if (finish && reported !== 1'b1) begin
            if (exp_rdata.size() != 0 || exp_plv.size() != 0) begin
                $display("%0d reads and %0d core checks were expected but never happened",
                         exp_rdata.size(), exp_plv.size());
                missing = missing + exp_rdata.size() + exp_plv.size();
            end
            $display("Errors: %0d read, %0d core, %0d response, %0d missing, %0d testbench",
                     read_errs, core_errs, resp_errs, missing, tb_errors);
            reported <= 1'b1;
        end
    end

endmodule

// File: sim/csr_chk.sv
module csr_chk (
    input logic clk,
    input logic aresetn,
    input logic awready,
    input logic wready,
    input logic arready,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic cpu_interrupt
);
    timeunit 1ns;
    timeprecision 1ps;

    bvalid_held: assert property (@(posedge clk) disable iff (!aresetn)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready was seen");

    rvalid_held: assert property (@(posedge clk) disable iff (!aresetn)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready was seen");

    // No new write while a response waits
    aw_blocked: assert property (@(posedge clk) disable iff (!aresetn)
        bvalid |-> !awready && !wready)
        else $error("awready or wready high while bvalid is pending");

    reset_state: assert property (@(posedge clk)
        !aresetn |=> !cpu_interrupt && !bvalid && !rvalid && awready && arready)
        else $error("Outputs not in their reset state after reset");

endmodule

bind csr_top csr_chk chk_i (
    .clk           (clk),
    .aresetn       (aresetn),
    .awready       (awready),
    .wready        (wready),
    .arready       (arready),
    .bvalid        (bvalid),
    .bready        (bready),
    .rvalid        (rvalid),
    .rready        (rready),
    .cpu_interrupt (cpu_interrupt)
);

// File: sim/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic aresetn
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        aresetn = 1'b0;
        repeat (2) @(posedge clk);
        aresetn <= 1'b1;
    end

endmodule

// File: logic/csr_top.sv
module csr_top #(
    parameter int TIMER_BITS = 32
) (
    input  logic               clk,
    input  logic               aresetn,

    input  logic               awvalid,
    output logic               awready,
    input  csr_pkg::axi_addr_t awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  csr_pkg::csr_word_t wdata,
    input  logic [3:0]         wstrb,
    output logic               bvalid,
    input  logic               bready,
    output logic [1:0]         bresp,

    input  logic               arvalid,
    output logic               arready,
    input  csr_pkg::axi_addr_t araddr,
    output logic               rvalid,
    input  logic               rready,
    output csr_pkg::csr_word_t rdata,
    output logic [1:0]         rresp,

    input  logic               excp_valid,
    input  csr_pkg::ecode_t    excp_code,
    input  csr_pkg::csr_word_t excp_pc,
    input  logic               ertn,
    input  logic [7:0]         hw_int,

    output csr_pkg::plv_t      plv,
    output logic               ie,
    output csr_pkg::csr_word_t era,
    output csr_pkg::csr_word_t eentry,
    output logic               cpu_interrupt
);

    logic timer_pending;

    csr_bus_if bus ();

    csr_axil_port port_i (
        .clk, .aresetn,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .bus (bus.port)
    );

    csr_except except_i (
        .clk, .aresetn, .excp_valid, .excp_code, .excp_pc, .ertn, .hw_int,
        .timer_pending,
        .bus (bus.except_side),
        .plv, .ie, .era, .eentry, .cpu_interrupt
    );

    csr_timer #(.TIMER_BITS(TIMER_BITS)) timer_i (
        .clk, .aresetn,
        .bus (bus.timer_side),
        .timer_pending
    );

endmodule

// File: logic/csr_timer.sv
module csr_timer #(
    parameter int TIMER_BITS = 32
) (
    input  logic          clk,
    input  logic          aresetn,
    csr_bus_if.timer_side bus,
    output logic          timer_pending
);

    csr_pkg::csr_word_t    tcfg_q;
    logic [TIMER_BITS-1:0] tval;
    logic [TIMER_BITS-1:0] wr_init;
    logic [TIMER_BITS-1:0] cfg_init;
    logic                  wr_tcfg;
    logic                  wr_ticlr;
    logic                  expire;

    assign wr_tcfg  = bus.wen && (bus.wnum == csr_pkg::CSR_TCFG);
    assign wr_ticlr = bus.wen && (bus.wnum == csr_pkg::CSR_TICLR);
    assign wr_init  = TIMER_BITS'(bus.wdata[31:csr_pkg::TCFG_INITVAL_LSB]);
    assign cfg_init = TIMER_BITS'(tcfg_q[31:csr_pkg::TCFG_INITVAL_LSB]);

    // Last count of a running timer
    assign expire = !wr_tcfg && tcfg_q[csr_pkg::TCFG_EN] && (tval == TIMER_BITS'(1));

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg_q <= '0;
            tval   <= '0;
        end else if (wr_tcfg) begin
            tcfg_q <= bus.wdata;
            tval   <= wr_init;
        end else if (expire) begin
            tval <= tcfg_q[csr_pkg::TCFG_PERIODIC] ? cfg_init : '0;
        end else if (tcfg_q[csr_pkg::TCFG_EN] && tval != '0) begin
            tval <= tval - 1'b1;
        end
    end

    // Expiry beats a TICLR write in the same cycle
    always_ff @(posedge clk) begin
        if (!aresetn)
            timer_pending <= 1'b0;
        else if (expire)
            timer_pending <= 1'b1;
        else if (wr_ticlr)
            timer_pending <= 1'b0;
    end

    always_comb begin
        case (bus.rnum)
            csr_pkg::CSR_TCFG:  bus.timer_rdata = tcfg_q;
            csr_pkg::CSR_TVAL:  bus.timer_rdata = csr_pkg::csr_word_t'(tval);
            csr_pkg::CSR_TICLR: bus.timer_rdata = '0;
            default:            bus.timer_rdata = '0;
        endcase
    end

endmodule

// File: logic/csr_except.sv
module csr_except (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               excp_valid,
    input  csr_pkg::ecode_t    excp_code,
    input  csr_pkg::csr_word_t excp_pc,
    input  logic               ertn,
    input  logic [7:0]         hw_int,
    input  logic               timer_pending,
    csr_bus_if.except_side     bus,
    output csr_pkg::plv_t      plv,
    output logic               ie,
    output csr_pkg::csr_word_t era,
    output csr_pkg::csr_word_t eentry,
    output logic               cpu_interrupt
);

    logic               excp_q;
    logic               excp_take;
    csr_pkg::csr_word_t crmd;
    csr_pkg::plv_t      prmd_pplv;
    logic               prmd_pie;
    csr_pkg::int_vec_t  ecfg_lie;
    logic [1:0]         estat_is_soft;
    csr_pkg::ecode_t    estat_ecode;
    csr_pkg::int_vec_t  int_status;
    logic               wr_crmd, wr_prmd, wr_ecfg, wr_estat, wr_era, wr_eentry;

    // Rising edge of excp_valid, ertn wins
    always_ff @(posedge clk) begin
        if (!aresetn)
            excp_q <= 1'b0;
        else
            excp_q <= excp_valid;
    end

    assign excp_take = excp_valid && !excp_q && !ertn;

    assign wr_crmd   = bus.wen && (bus.wnum == csr_pkg::CSR_CRMD);
    assign wr_prmd   = bus.wen && (bus.wnum == csr_pkg::CSR_PRMD);
    assign wr_ecfg   = bus.wen && (bus.wnum == csr_pkg::CSR_ECFG);
    assign wr_estat  = bus.wen && (bus.wnum == csr_pkg::CSR_ESTAT);
    assign wr_era    = bus.wen && (bus.wnum == csr_pkg::CSR_ERA);
    assign wr_eentry = bus.wen && (bus.wnum == csr_pkg::CSR_EENTRY);

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd <= csr_pkg::CRMD_RESET;
        end else if (ertn) begin
            crmd[csr_pkg::CRMD_PLV_LSB +: 2] <= prmd_pplv;
            crmd[csr_pkg::CRMD_IE]           <= prmd_pie;
        end else if (excp_take) begin
            crmd[csr_pkg::CRMD_PLV_LSB +: 2] <= '0;
            crmd[csr_pkg::CRMD_IE]           <= 1'b0;
        end else if (wr_crmd) begin
            crmd <= bus.wdata & csr_pkg::CRMD_WMASK;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd_pplv     <= '0;
            prmd_pie      <= 1'b0;
            estat_ecode   <= '0;
            estat_is_soft <= '0;
            era           <= '0;
        end else if (excp_take) begin
            prmd_pplv   <= crmd[csr_pkg::CRMD_PLV_LSB +: 2];
            prmd_pie    <= crmd[csr_pkg::CRMD_IE];
            estat_ecode <= excp_code;
            era         <= excp_pc;
        end else begin
            if (wr_prmd) begin
                prmd_pplv <= bus.wdata[csr_pkg::PRMD_PPLV_LSB +: 2];
                prmd_pie  <= bus.wdata[csr_pkg::PRMD_PIE];
            end
            // Only the software interrupt bits are writable
            if (wr_estat)
                estat_is_soft <= bus.wdata[csr_pkg::INT_SOFT_LSB +: 2];
            if (wr_era)
                era <= bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecfg_lie <= '0;
            eentry   <= '0;
        end else begin
            if (wr_ecfg)
                ecfg_lie <= bus.wdata[12:0] & csr_pkg::ECFG_LIE_MASK;
            if (wr_eentry)
                eentry <= bus.wdata & csr_pkg::EENTRY_MASK;
        end
    end

    always_comb begin
        int_status = '0;
        int_status[csr_pkg::INT_SOFT_LSB +: 2] = estat_is_soft;
        int_status[csr_pkg::INT_HW_LSB +: 8]   = hw_int;
        int_status[csr_pkg::INT_TIMER]         = timer_pending;
    end

    always_comb begin
        bus.except_rdata = '0;
        case (bus.rnum)
            csr_pkg::CSR_CRMD: bus.except_rdata = crmd;
            csr_pkg::CSR_PRMD: begin
                bus.except_rdata[csr_pkg::PRMD_PPLV_LSB +: 2] = prmd_pplv;
                bus.except_rdata[csr_pkg::PRMD_PIE]           = prmd_pie;
            end
            csr_pkg::CSR_ECFG: bus.except_rdata[12:0] = ecfg_lie;
            csr_pkg::CSR_ESTAT: begin
                bus.except_rdata[12:0]                          = int_status;
                bus.except_rdata[csr_pkg::ESTAT_ECODE_LSB +: 6] = estat_ecode;
            end
            csr_pkg::CSR_ERA:    bus.except_rdata = era;
            csr_pkg::CSR_EENTRY: bus.except_rdata = eentry;
            default:             bus.except_rdata = '0;
        endcase
    end

    assign plv           = crmd[csr_pkg::CRMD_PLV_LSB +: 2];
    assign ie            = crmd[csr_pkg::CRMD_IE];
    assign cpu_interrupt = ie && |(ecfg_lie & int_status);

endmodule

// File: logic/csr_axil_port.sv
module csr_axil_port (
    input  logic               clk,
    input  logic               aresetn,

    input  logic               awvalid,
    output logic               awready,
    input  csr_pkg::axi_addr_t awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  csr_pkg::csr_word_t wdata,
    input  logic [3:0]         wstrb,
    output logic               bvalid,
    input  logic               bready,
    output logic [1:0]         bresp,

    input  logic               arvalid,
    output logic               arready,
    input  csr_pkg::axi_addr_t araddr,
    output logic               rvalid,
    input  logic               rready,
    output csr_pkg::csr_word_t rdata,
    output logic [1:0]         rresp,

    csr_bus_if.port            bus
);

    typedef enum logic {W_IDLE, W_RESP} wr_state_t;
    typedef enum logic {R_IDLE, R_RESP} rd_state_t;

    wr_state_t w_state;
    rd_state_t r_state;
    logic      w_accept;
    logic      r_accept;

    assign awready  = (w_state == W_IDLE);
    assign wready   = (w_state == W_IDLE);
    assign arready  = (r_state == R_IDLE);
    assign w_accept = awvalid && wvalid && awready && wready;
    assign r_accept = arvalid && arready;

    // Byte strobes ignored, writes are always full words
    assign bus.wen   = w_accept;
    assign bus.wnum  = awaddr[15:2];
    assign bus.wdata = wdata;
    assign bus.rnum  = araddr[15:2];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            w_state <= W_IDLE;
        end else if (w_state == W_IDLE) begin
            if (w_accept)
                w_state <= W_RESP;
        end else if (bready) begin
            w_state <= W_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            r_state <= R_IDLE;
        end else if (r_state == R_IDLE) begin
            if (r_accept)
                r_state <= R_RESP;
        end else if (rready) begin
            r_state <= R_IDLE;
        end
    end

    // Held until rready
    always_ff @(posedge clk) begin
        if (r_accept)
            rdata <= bus.except_rdata | bus.timer_rdata;
    end

    assign bvalid = (w_state == W_RESP);
    assign rvalid = (r_state == R_RESP);
    assign bresp  = 2'b00;
    assign rresp  = 2'b00;

endmodule

// File: logic/csr_bus_if.sv
interface csr_bus_if;

    logic               wen;
    csr_pkg::csr_num_t  wnum;
    csr_pkg::csr_word_t wdata;
    csr_pkg::csr_num_t  rnum;
    csr_pkg::csr_word_t except_rdata;
    csr_pkg::csr_word_t timer_rdata;

    modport port (
        output wen, wnum, wdata, rnum,
        input  except_rdata, timer_rdata
    );

    modport except_side (
        input  wen, wnum, wdata, rnum,
        output except_rdata
    );

    modport timer_side (
        input  wen, wnum, wdata, rnum,
        output timer_rdata
    );

endinterface

// File: logic/csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] csr_word_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [15:0] axi_addr_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [1:0]  plv_t;
    typedef logic [12:0] int_vec_t;

    // CSR numbers
    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_ECFG   = 14'h4;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_EENTRY = 14'hC;
    localparam csr_num_t CSR_TCFG   = 14'h41;
    localparam csr_num_t CSR_TVAL   = 14'h42;
    localparam csr_num_t CSR_TICLR  = 14'h44;

    // Field positions
    localparam int CRMD_PLV_LSB     = 0;
    localparam int CRMD_IE          = 2;
    localparam int CRMD_DA          = 3;
    localparam int PRMD_PPLV_LSB    = 0;
    localparam int PRMD_PIE         = 2;
    localparam int ESTAT_ECODE_LSB  = 16;
    localparam int INT_SOFT_LSB     = 0;
    localparam int INT_HW_LSB       = 2;
    localparam int INT_TIMER        = 11;
    localparam int TCFG_EN          = 0;
    localparam int TCFG_PERIODIC    = 1;
    localparam int TCFG_INITVAL_LSB = 2;

    // PLV, IE, DA, PG, DATF and DATM are writable
    localparam csr_word_t CRMD_WMASK    = 32'h0000_01FF;
    localparam csr_word_t CRMD_RESET    = 32'h1 << CRMD_DA;
    localparam csr_word_t EENTRY_MASK   = 32'hFFFF_FFC0;
    localparam int_vec_t  ECFG_LIE_MASK = 13'b1_1011_1111_1111;

endpackage
